// File: mem_geom_pkg.sv
package mem_geom_pkg;

  // port counts
  localparam int NUMRDPT = 2;
  localparam int NUMWRPT = 3;

  // bank array, six banks so the bank is not a plain bit field
  localparam int NUMVBNK = 6;
  localparam int BITVBNK = 3;

  // rows per bank
  localparam int NUMVROW = 64;
  localparam int BITVROW = 6;

  // logical address space, banks times rows
  localparam int NUMADDR = NUMVBNK * NUMVROW;
  localparam int BITADDR = 9;

  // physical address is {bank, row}
  localparam int BITPADR = BITVBNK + BITVROW;

endpackage

// File: mem_timing_pkg.sv
package mem_timing_pkg;

  localparam int WIDTH = 32;       // bits per data word

  // cycles from a bank read request to its data
  localparam int SRAM_DELAY = 2;

  typedef logic [WIDTH-1:0] data_t;

endpackage

// File: np2_addr.sv
`timescale 1ns/10ps

module np2_addr (
  input  logic [mem_geom_pkg::BITADDR-1:0] vaddr,
  output logic [mem_geom_pkg::BITVBNK-1:0] vbadr,
  output logic [mem_geom_pkg::BITVROW-1:0] vradr,
  output logic                             range_err
);

  logic [mem_geom_pkg::BITVBNK:0]   divisor;
  logic [mem_geom_pkg::BITVBNK:0]   rem;
  logic [mem_geom_pkg::BITADDR-1:0] quo;

  assign divisor = mem_geom_pkg::NUMVBNK[mem_geom_pkg::BITVBNK:0];

  // restoring division by the bank count, one quotient bit per address bit
  always_comb begin
    rem = '0;
    quo = '0;
    for (int i = mem_geom_pkg::BITADDR - 1; i >= 0; i--) begin
      rem = {rem[mem_geom_pkg::BITVBNK-1:0], vaddr[i]}; // rem stays below divisor
      if (rem >= divisor) begin
        rem    = rem - divisor;
        quo[i] = 1'b1;
      end
    end
  end

  assign vbadr = rem[mem_geom_pkg::BITVBNK-1:0]; // address mod banks
  assign vradr = quo[mem_geom_pkg::BITVROW-1:0]; // address div banks

  assign range_err = (vaddr >= mem_geom_pkg::NUMADDR);

endmodule

// File: sram_bank_1r1w.sv
`timescale 1ns/10ps

module sram_bank_1r1w (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             t1_writeA,
  input  logic [mem_geom_pkg::BITVROW-1:0] t1_addrA,
  input  mem_timing_pkg::data_t            t1_dinA,
  input  logic                             t1_readB,
  input  logic [mem_geom_pkg::BITVROW-1:0] t1_addrB,
  output mem_timing_pkg::data_t            t1_doutB
);

  mem_timing_pkg::data_t mem [mem_geom_pkg::NUMVROW];

  // read data pipeline, stage 0 holds the array word
  mem_timing_pkg::data_t data_q [mem_timing_pkg::SRAM_DELAY];
  logic                  vld_q  [mem_timing_pkg::SRAM_DELAY];

  // storage array, port A write
  always_ff @(posedge clk) begin
    if (t1_writeA) begin
      mem[t1_addrA] <= t1_dinA;
    end
  end

  // port B sees the array before a same-edge write lands
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < mem_timing_pkg::SRAM_DELAY; k++) begin
        data_q[k] <= '0;
        vld_q[k]  <= 1'b0;
      end
    end else begin
      vld_q[0] <= t1_readB;
      if (t1_readB) begin
        data_q[0] <= mem[t1_addrB];
      end
      for (int k = 1; k < mem_timing_pkg::SRAM_DELAY; k++) begin
        data_q[k] <= data_q[k-1];
        vld_q[k]  <= vld_q[k-1];
      end
    end
  end

  // idle bank drives zero so the return mux sees clean data
  assign t1_doutB = vld_q[mem_timing_pkg::SRAM_DELAY-1] ?
                    data_q[mem_timing_pkg::SRAM_DELAY-1] : '0;

endmodule

// File: bank_port_router.sv
`timescale 1ns/10ps

module bank_port_router (
  input  logic [mem_geom_pkg::NUMRDPT-1:0]                      read,
  input  logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITADDR-1:0] rd_adr,
  input  logic [mem_geom_pkg::NUMWRPT-1:0]                      write,
  input  logic [mem_geom_pkg::NUMWRPT*mem_geom_pkg::BITADDR-1:0] wr_adr,
  input  logic [mem_geom_pkg::NUMWRPT*mem_timing_pkg::WIDTH-1:0] din,
  output logic                                                   req_ready,
  output logic [mem_geom_pkg::NUMVBNK-1:0]                      t1_writeA,
  output logic [mem_geom_pkg::NUMVBNK*mem_geom_pkg::BITVROW-1:0] t1_addrA,
  output logic [mem_geom_pkg::NUMVBNK*mem_timing_pkg::WIDTH-1:0] t1_dinA,
  output logic [mem_geom_pkg::NUMVBNK-1:0]                      t1_readB,
  output logic [mem_geom_pkg::NUMVBNK*mem_geom_pkg::BITVROW-1:0] t1_addrB,
  output logic [mem_geom_pkg::NUMRDPT-1:0]                      rd_accept,
  output logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITVBNK-1:0] rd_bank,
  output logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITVROW-1:0] rd_row,
  input  logic                                                   rst
);

  logic [mem_geom_pkg::BITVBNK-1:0] rd_bnk [mem_geom_pkg::NUMRDPT];
  logic [mem_geom_pkg::BITVROW-1:0] rd_rw  [mem_geom_pkg::NUMRDPT];
  logic [mem_geom_pkg::NUMRDPT-1:0] rd_rerr;
  logic [mem_geom_pkg::BITVBNK-1:0] wr_bnk [mem_geom_pkg::NUMWRPT];
  logic [mem_geom_pkg::BITVROW-1:0] wr_rw  [mem_geom_pkg::NUMWRPT];
  logic [mem_geom_pkg::NUMWRPT-1:0] wr_rerr;
  mem_timing_pkg::data_t            wr_din [mem_geom_pkg::NUMWRPT];

  logic same_bank;
  logic range_bad;
  logic req_fire;

  // per-bank request lines before packing
  logic [mem_geom_pkg::BITVROW-1:0] addr_a [mem_geom_pkg::NUMVBNK];
  logic [mem_geom_pkg::BITVROW-1:0] addr_b [mem_geom_pkg::NUMVBNK];
  mem_timing_pkg::data_t            din_a  [mem_geom_pkg::NUMVBNK];

  for (genvar i = 0; i < mem_geom_pkg::NUMRDPT; i++) begin : g_rd_dec
    np2_addr u_dec (
      .vaddr     (rd_adr[i*mem_geom_pkg::BITADDR +: mem_geom_pkg::BITADDR]),
      .vbadr     (rd_bnk[i]),
      .vradr     (rd_rw[i]),
      .range_err (rd_rerr[i])
    );
    assign rd_bank[i*mem_geom_pkg::BITVBNK +: mem_geom_pkg::BITVBNK] = rd_bnk[i];
    assign rd_row[i*mem_geom_pkg::BITVROW +: mem_geom_pkg::BITVROW]  = rd_rw[i];
  end

  for (genvar i = 0; i < mem_geom_pkg::NUMWRPT; i++) begin : g_wr_dec
    np2_addr u_dec (
      .vaddr     (wr_adr[i*mem_geom_pkg::BITADDR +: mem_geom_pkg::BITADDR]),
      .vbadr     (wr_bnk[i]),
      .vradr     (wr_rw[i]),
      .range_err (wr_rerr[i])
    );
    assign wr_din[i] = din[i*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH];
  end

  // pairwise bank compare, reads against reads and writes against writes
  always_comb begin
    same_bank = 1'b0;
    for (int i = 0; i < mem_geom_pkg::NUMRDPT; i++) begin
      for (int j = i + 1; j < mem_geom_pkg::NUMRDPT; j++) begin
        if (read[i] && read[j] && (rd_bnk[i] == rd_bnk[j])) begin
          same_bank = 1'b1;
        end
      end
    end
    for (int i = 0; i < mem_geom_pkg::NUMWRPT; i++) begin
      for (int j = i + 1; j < mem_geom_pkg::NUMWRPT; j++) begin
        if (write[i] && write[j] && (wr_bnk[i] == wr_bnk[j])) begin
          same_bank = 1'b1;
        end
      end
    end
  end

  assign range_bad = (|(read & rd_rerr)) || (|(write & wr_rerr));

  // whole request set is refused on any conflict
  assign req_ready = !rst && !same_bank && !range_bad;
  assign req_fire  = req_ready && (|read || |write);
  assign rd_accept = read & {mem_geom_pkg::NUMRDPT{req_fire}};

  always_comb begin
    t1_writeA = '0;
    t1_readB  = '0;
    for (int b = 0; b < mem_geom_pkg::NUMVBNK; b++) begin
      addr_a[b] = '0;
      addr_b[b] = '0;
      din_a[b]  = '0;
    end
    for (int w = 0; w < mem_geom_pkg::NUMWRPT; w++) begin
      if (req_fire && write[w]) begin
        t1_writeA[wr_bnk[w]] = 1'b1;
        addr_a[wr_bnk[w]]    = wr_rw[w];
        din_a[wr_bnk[w]]     = wr_din[w];
      end
    end
    for (int r = 0; r < mem_geom_pkg::NUMRDPT; r++) begin
      if (req_fire && read[r]) begin
        t1_readB[rd_bnk[r]] = 1'b1;
        addr_b[rd_bnk[r]]   = rd_rw[r];
      end
    end
  end

  for (genvar b = 0; b < mem_geom_pkg::NUMVBNK; b++) begin : g_pack
    assign t1_addrA[b*mem_geom_pkg::BITVROW +: mem_geom_pkg::BITVROW]  = addr_a[b];
    assign t1_addrB[b*mem_geom_pkg::BITVROW +: mem_geom_pkg::BITVROW]  = addr_b[b];
    assign t1_dinA[b*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH] = din_a[b];
  end

endmodule

// File: read_return.sv
`timescale 1ns/10ps

module read_return (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic [mem_geom_pkg::NUMRDPT-1:0]                      rd_accept,
  input  logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITVBNK-1:0] rd_bank,
  input  logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITVROW-1:0] rd_row,
  input  logic [mem_geom_pkg::NUMVBNK*mem_timing_pkg::WIDTH-1:0] t1_doutB,
  output logic [mem_geom_pkg::NUMRDPT-1:0]                      rd_vld,
  output logic [mem_geom_pkg::NUMRDPT*mem_timing_pkg::WIDTH-1:0] rd_dout,
  output logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITPADR-1:0] rd_padr
);

  mem_timing_pkg::data_t bank_dout [mem_geom_pkg::NUMVBNK];

  for (genvar b = 0; b < mem_geom_pkg::NUMVBNK; b++) begin : g_unpack
    assign bank_dout[b] = t1_doutB[b*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH];
  end

  for (genvar p = 0; p < mem_geom_pkg::NUMRDPT; p++) begin : g_port
    // one record per cycle in flight, same depth as the bank pipeline
    logic                             vld_q  [mem_timing_pkg::SRAM_DELAY];
    logic [mem_geom_pkg::BITVBNK-1:0] bank_q [mem_timing_pkg::SRAM_DELAY];
    logic [mem_geom_pkg::BITVROW-1:0] row_q  [mem_timing_pkg::SRAM_DELAY];
    logic [mem_geom_pkg::BITVBNK-1:0] out_bank;
    logic [mem_geom_pkg::BITVROW-1:0] out_row;

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int k = 0; k < mem_timing_pkg::SRAM_DELAY; k++) begin
          vld_q[k] <= 1'b0;
        end
      end else begin
        vld_q[0] <= rd_accept[p];
        for (int k = 1; k < mem_timing_pkg::SRAM_DELAY; k++) begin
          vld_q[k] <= vld_q[k-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      bank_q[0] <= rd_bank[p*mem_geom_pkg::BITVBNK +: mem_geom_pkg::BITVBNK];
      row_q[0]  <= rd_row[p*mem_geom_pkg::BITVROW +: mem_geom_pkg::BITVROW];
      for (int k = 1; k < mem_timing_pkg::SRAM_DELAY; k++) begin
        bank_q[k] <= bank_q[k-1];
        row_q[k]  <= row_q[k-1];
      end
    end

    assign out_bank = bank_q[mem_timing_pkg::SRAM_DELAY-1];
    assign out_row  = row_q[mem_timing_pkg::SRAM_DELAY-1];

    assign rd_vld[p] = vld_q[mem_timing_pkg::SRAM_DELAY-1];
    assign rd_dout[p*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH] =
      bank_dout[out_bank];                                      // bank picked at request time
    assign rd_padr[p*mem_geom_pkg::BITPADR +: mem_geom_pkg::BITPADR] = {out_bank, out_row};
  end

endmodule

// File: mrnw_banked_mem.sv
`timescale 1ns/10ps

module mrnw_banked_mem (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic [mem_geom_pkg::NUMRDPT-1:0]                      read,
  input  logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITADDR-1:0] rd_adr,
  input  logic [mem_geom_pkg::NUMWRPT-1:0]                      write,
  input  logic [mem_geom_pkg::NUMWRPT*mem_geom_pkg::BITADDR-1:0] wr_adr,
  input  logic [mem_geom_pkg::NUMWRPT*mem_timing_pkg::WIDTH-1:0] din,
  output logic                                                   req_ready,
  output logic [mem_geom_pkg::NUMRDPT-1:0]                      rd_vld,
  output logic [mem_geom_pkg::NUMRDPT*mem_timing_pkg::WIDTH-1:0] rd_dout,
  output logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITPADR-1:0] rd_padr
);

  logic [mem_geom_pkg::NUMVBNK-1:0]                      t1_writeA;
  logic [mem_geom_pkg::NUMVBNK*mem_geom_pkg::BITVROW-1:0] t1_addrA;
  logic [mem_geom_pkg::NUMVBNK*mem_timing_pkg::WIDTH-1:0] t1_dinA;
  logic [mem_geom_pkg::NUMVBNK-1:0]                      t1_readB;
  logic [mem_geom_pkg::NUMVBNK*mem_geom_pkg::BITVROW-1:0] t1_addrB;
  logic [mem_geom_pkg::NUMVBNK*mem_timing_pkg::WIDTH-1:0] t1_doutB;
  logic [mem_geom_pkg::NUMRDPT-1:0]                      rd_accept;
  logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITVBNK-1:0] rd_bank;
  logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITVROW-1:0] rd_row;

  bank_port_router u_router (
    .read      (read),
    .rd_adr    (rd_adr),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .req_ready (req_ready),
    .t1_writeA (t1_writeA),
    .t1_addrA  (t1_addrA),
    .t1_dinA   (t1_dinA),
    .t1_readB  (t1_readB),
    .t1_addrB  (t1_addrB),
    .rd_accept (rd_accept),
    .rd_bank   (rd_bank),
    .rd_row    (rd_row),
    .rst       (rst)
  );

  for (genvar b = 0; b < mem_geom_pkg::NUMVBNK; b++) begin : g_bank
    sram_bank_1r1w u_bank (
      .clk       (clk),
      .rst       (rst),
      .t1_writeA (t1_writeA[b]),
      .t1_addrA  (t1_addrA[b*mem_geom_pkg::BITVROW +: mem_geom_pkg::BITVROW]),
      .t1_dinA   (t1_dinA[b*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH]),
      .t1_readB  (t1_readB[b]),
      .t1_addrB  (t1_addrB[b*mem_geom_pkg::BITVROW +: mem_geom_pkg::BITVROW]),
      .t1_doutB  (t1_doutB[b*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH])
    );
  end

  read_return u_return (
    .clk       (clk),
    .rst       (rst),
    .rd_accept (rd_accept),
    .rd_bank   (rd_bank),
    .rd_row    (rd_row),
    .t1_doutB  (t1_doutB),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr)
  );

endmodule

// File: tb_mrnw_banked_mem.sv
`timescale 1ns/10ps

module tb_mrnw_banked_mem;

  typedef logic [32+mem_geom_pkg::BITPADR+mem_timing_pkg::WIDTH-1:0] rec_t;

  logic                                                   clk;
  logic                                                   rst;
  logic [mem_geom_pkg::NUMRDPT-1:0]                      read;
  logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITADDR-1:0] rd_adr;
  logic [mem_geom_pkg::NUMWRPT-1:0]                      write;
  logic [mem_geom_pkg::NUMWRPT*mem_geom_pkg::BITADDR-1:0] wr_adr;
  logic [mem_geom_pkg::NUMWRPT*mem_timing_pkg::WIDTH-1:0] din;
  logic                                                   req_ready;
  logic [mem_geom_pkg::NUMRDPT-1:0]                      rd_vld;
  logic [mem_geom_pkg::NUMRDPT*mem_timing_pkg::WIDTH-1:0] rd_dout;
  logic [mem_geom_pkg::NUMRDPT*mem_geom_pkg::BITPADR-1:0] rd_padr;

  mem_timing_pkg::data_t shadow [mem_geom_pkg::NUMADDR];
  rec_t                  exp_q0 [$];                    // {due cycle, padr, data}
  rec_t                  exp_q1 [$];

  logic [31:0] cyc = '0;
  logic [31:0] lfsr_state = 32'h1b12625e;
  string       cur_test = "none";
  int          checks = 0;
  int          mismatches = 0;
  int          other_errors = 0;

  mrnw_banked_mem UUT (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .rd_adr    (rd_adr),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .req_ready (req_ready),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [mem_geom_pkg::BITADDR-1:0] rand_addr();
    return rand_bits(mem_geom_pkg::BITADDR) % mem_geom_pkg::NUMADDR;
  endfunction

  function automatic logic [mem_geom_pkg::BITADDR-1:0] make_addr(input int bank, input int row);
    return row * mem_geom_pkg::NUMVBNK + bank;
  endfunction

  // bank is the address mod six, row the address div six
  function automatic logic [mem_geom_pkg::BITPADR-1:0] expected_padr(input int addr);
    logic [mem_geom_pkg::BITVBNK-1:0] bank;
    logic [mem_geom_pkg::BITVROW-1:0] row;
    bank = addr % mem_geom_pkg::NUMVBNK;
    row  = addr / mem_geom_pkg::NUMVBNK;
    return {bank, row};
  endfunction

  task automatic check(input string what, input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch test=%s %s expected=%0h actual=%0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("checks=%0d mismatches=%0d other_errors=%0d", checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic clear_req();
    read   = '0;
    rd_adr = '0;
    write  = '0;
    wr_adr = '0;
    din    = '0;
  endtask

  task automatic set_read(input int p, input logic [mem_geom_pkg::BITADDR-1:0] addr);
    read[p] = 1'b1;
    rd_adr[p*mem_geom_pkg::BITADDR +: mem_geom_pkg::BITADDR] = addr;
  endtask

  task automatic set_write(input int w, input logic [mem_geom_pkg::BITADDR-1:0] addr,
                           input mem_timing_pkg::data_t data);
    write[w] = 1'b1;
    wr_adr[w*mem_geom_pkg::BITADDR +: mem_geom_pkg::BITADDR] = addr;
    din[w*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH]     = data;
  endtask

  task automatic push_expect(input int p, input rec_t rec);
    if (p == 0) begin
      exp_q0.push_back(rec);
    end else begin
      exp_q1.push_back(rec);
    end
  endtask

  // called at a falling edge with the request set already driven
  task automatic run_cycle(input logic exp_ready);
    logic [31:0] due;
    logic        ready;
    int          a;
    due = cyc + mem_timing_pkg::SRAM_DELAY;   // held for the edge SRAM_DELAY after acceptance
    @(posedge clk);
    ready = req_ready;
    check("req_ready", exp_ready, ready);
    if (ready && (|read || |write)) begin
      for (int p = 0; p < mem_geom_pkg::NUMRDPT; p++) begin
        if (read[p]) begin
          a = rd_adr[p*mem_geom_pkg::BITADDR +: mem_geom_pkg::BITADDR];
          push_expect(p, {due, expected_padr(a), shadow[a]}); // old data before writes
        end
      end
      for (int w = 0; w < mem_geom_pkg::NUMWRPT; w++) begin
        if (write[w]) begin
          a = wr_adr[w*mem_geom_pkg::BITADDR +: mem_geom_pkg::BITADDR];
          shadow[a] = din[w*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH];
        end
      end
    end
    @(negedge clk);
    clear_req();
  endtask

  task automatic check_return(input int p);
    rec_t rec;
    int   pending;
    pending = (p == 0) ? exp_q0.size() : exp_q1.size();
    if (pending == 0) begin
      other_errors++;
      $display("Read port %0d returned data that was never requested in test %s", p, cur_test);
    end else begin
      if (p == 0) begin
        rec = exp_q0.pop_front();
      end else begin
        rec = exp_q1.pop_front();
      end
      check("rd_dout", rec[mem_timing_pkg::WIDTH-1:0],
            rd_dout[p*mem_timing_pkg::WIDTH +: mem_timing_pkg::WIDTH]);
      check("rd_padr", rec[mem_timing_pkg::WIDTH +: mem_geom_pkg::BITPADR],
            rd_padr[p*mem_geom_pkg::BITPADR +: mem_geom_pkg::BITPADR]);
      check("rd_vld cycle", rec[mem_timing_pkg::WIDTH+mem_geom_pkg::BITPADR +: 32], cyc);
    end
  endtask

  // read results are sampled half a cycle after the edge that raised them
  always @(negedge clk) begin
    for (int p = 0; p < mem_geom_pkg::NUMRDPT; p++) begin
      if (rd_vld[p] === 1'b1) begin
        check_return(p);
      end
    end
  end

  task automatic wait_reads_done();
    int n;
    n = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      other_errors++;
      $display("Timeout: %0d read results never arrived in test %s",
               exp_q0.size() + exp_q1.size(), cur_test);
      exp_q0.delete();
      exp_q1.delete();
    end
    @(negedge clk);
  endtask

  task automatic reset_state();
    cur_test = "reset_state";
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check("rd_vld in reset", '0, rd_vld);
      check("req_ready in reset", 1'b0, req_ready);
      set_read(0, 9'd7);                                // legal read, still blocked
    end
    rst = 1'b0;
    clear_req();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check("rd_vld after reset", '0, rd_vld);
      check("req_ready idle", 1'b1, req_ready);
    end
  endtask

  task automatic single_port_write_read();
    logic [mem_geom_pkg::BITADDR-1:0] addrs [mem_geom_pkg::NUMWRPT];
    cur_test = "single_port_write_read";
    for (int round = 0; round < 4; round++) begin
      for (int w = 0; w < mem_geom_pkg::NUMWRPT; w++) begin
        addrs[w] = rand_addr();
        set_write(w, addrs[w], rand_bits(32));
        run_cycle(1'b1);
      end
      for (int r = 0; r < mem_geom_pkg::NUMRDPT; r++) begin
        for (int i = 0; i < mem_geom_pkg::NUMWRPT; i++) begin
          set_read(r, addrs[i]);
          run_cycle(1'b1);
        end
      end
      wait_reads_done();
    end
  endtask

  task automatic multi_port_no_conflict();
    logic [mem_geom_pkg::BITADDR-1:0] addrs [mem_geom_pkg::NUMWRPT];
    logic [mem_geom_pkg::BITADDR-1:0] odd   [mem_geom_pkg::NUMWRPT];
    cur_test = "multi_port_no_conflict";
    for (int w = 0; w < mem_geom_pkg::NUMWRPT; w++) begin
      addrs[w] = make_addr(2 * w, rand_bits(6));          // banks 0, 2, 4
      set_write(w, addrs[w], rand_bits(32));
    end
    run_cycle(1'b1);
    set_read(0, addrs[2]);
    set_read(1, addrs[0]);
    run_cycle(1'b1);
    // five requests at once, writes on odd banks
    for (int w = 0; w < mem_geom_pkg::NUMWRPT; w++) begin
      odd[w] = make_addr(2 * w + 1, rand_bits(6));
      set_write(w, odd[w], rand_bits(32));
    end
    set_read(0, addrs[1]);
    set_read(1, addrs[2]);
    run_cycle(1'b1);
    set_read(0, odd[0]);
    set_read(1, odd[2]);
    run_cycle(1'b1);
    set_read(1, odd[1]);
    run_cycle(1'b1);
    wait_reads_done();
  endtask

  task automatic bank_conflict_refused();
    int                               bank;
    logic [mem_geom_pkg::BITVROW-1:0] row;
    logic [mem_geom_pkg::BITADDR-1:0] a0;
    logic [mem_geom_pkg::BITADDR-1:0] a1;
    cur_test = "bank_conflict_refused";
    bank = rand_bits(8) % mem_geom_pkg::NUMVBNK;
    row  = rand_bits(6);
    a0   = make_addr(bank, row);
    a1   = make_addr(bank, row ^ 6'd1);
    set_write(0, a0, rand_bits(32));
    run_cycle(1'b1);
    set_write(1, a1, rand_bits(32));
    run_cycle(1'b1);
    set_read(0, a0);
    set_read(1, a1);
    run_cycle(1'b0);
    set_write(0, a0, rand_bits(32));
    set_write(2, a1, rand_bits(32));
    run_cycle(1'b0);
    set_read(0, a0);                                      // must still hold the first data
    run_cycle(1'b1);
    set_read(1, a1);
    run_cycle(1'b1);
    wait_reads_done();
  endtask

  task automatic range_refused();
    cur_test = "range_refused";
    set_read(0, 9'd384);
    run_cycle(1'b0);
    set_read(0, 9'd10);
    set_read(1, 9'd511);
    run_cycle(1'b0);
    set_write(2, 9'd400, rand_bits(32));
    run_cycle(1'b0);
    set_write(0, 9'd383, rand_bits(32));                  // last legal address
    run_cycle(1'b1);
    set_read(1, 9'd383);
    run_cycle(1'b1);
    wait_reads_done();
  endtask

  task automatic back_to_back_reads();
    logic [mem_geom_pkg::BITADDR-1:0] addrs [4];
    cur_test = "back_to_back_reads";
    for (int i = 0; i < 4; i++) begin
      addrs[i] = make_addr(i, rand_bits(6));
      set_write(i % mem_geom_pkg::NUMWRPT, addrs[i], rand_bits(32));
      run_cycle(1'b1);
    end
    set_read(0, addrs[0]);
    set_read(1, addrs[1]);
    run_cycle(1'b1);
    set_read(0, addrs[2]);
    set_write(2, addrs[2], rand_bits(32));                // same row, read gets old word
    run_cycle(1'b1);
    set_read(1, addrs[2]);
    run_cycle(1'b1);
    set_read(0, addrs[3]);
    set_read(1, addrs[0]);
    run_cycle(1'b1);
    wait_reads_done();
  endtask

  initial begin
    int n;
    n = 0;
    while (n < 5000) begin
      @(posedge clk);
      n++;
    end
    other_errors++;
    $display("Simulation timed out before all tests finished in test %s", cur_test);
    finish_run();
  end

  initial begin
    rst = 1'b1;
    clear_req();
    reset_state();
    single_port_write_read();
    multi_port_no_conflict();
    bank_conflict_refused();
    range_refused();
    back_to_back_reads();
    finish_run();
  end

endmodule

// File: mrnw_banked_mem.f
mem_geom_pkg.sv
mem_timing_pkg.sv
np2_addr.sv
sram_bank_1r1w.sv
bank_port_router.sv
read_return.sv
mrnw_banked_mem.sv
tb_mrnw_banked_mem.sv
